//--- source/wb_mem_pkg.sv
// bus widths, RAM depths and the address map shared by the wishbone memory RTL and its testbench
package wb_mem_pkg;

    // wishbone bus widths
    // the bus is a plain 32-bit classic wishbone with one select bit per byte
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // RAM depths in 32-bit words
    // both depths must stay powers of two because the slaves take the
    // word index straight from the address bits above the byte offset
    localparam int MAIN_WORDS    = 256;
    localparam int SCRATCH_WORDS = 64;

    // main RAM window
    // 1 KB starting at the bottom of the address space
    localparam logic [WB_ADR_W-1:0] MAIN_BASE = 32'h0000_0000;

    // length of the main RAM window in bytes
    localparam logic [WB_ADR_W-1:0] MAIN_SPAN = MAIN_WORDS * WB_SEL_W;

    // scratch RAM window
    // 256 B placed well clear of the main RAM so that a word offset
    // in one window never aliases into the other
    localparam logic [WB_ADR_W-1:0] SCRATCH_BASE = 32'h0000_1000;

    // length of the scratch RAM window in bytes
    localparam logic [WB_ADR_W-1:0] SCRATCH_SPAN = SCRATCH_WORDS * WB_SEL_W;

    // each base is aligned to its own window size, so a slave can use
    // the low address bits as its word index without subtracting the base

    // every address outside the two windows is unmapped and the decoder
    // answers it with err instead of ack

    // the window sizes follow from the depths above, so growing a RAM
    // only needs a new depth here and a check that the windows still
    // do not overlap

    // the bench also reads MAIN_BASE and SCRATCH_BASE when it prints
    // where a failing access landed

endpackage

//--- source/soc_mem.sv
// behavioral single-port RAM with byte-lane writes and a registered read port, used inside mem_wb
`timescale 1ns/1ps

module soc_mem #(
    // depth in 32-bit words, a power of two
    parameter int MEM_WORDS = wb_mem_pkg::MAIN_WORDS,
    // word address width follows from the depth
    localparam int ADR_W = $clog2(MEM_WORDS)
) (
    input  logic                            wb_clk_i,
    input  logic                            ena_i,
    input  logic [wb_mem_pkg::WB_SEL_W-1:0] wen_i,
    input  logic [ADR_W-1:0]                addr_i,
    input  logic [wb_mem_pkg::WB_DAT_W-1:0] wdata_i,
    output logic [wb_mem_pkg::WB_DAT_W-1:0] rdata_o
);
    import wb_mem_pkg::*;

    // storage array
    // the contents come up undefined, as in a real SRAM macro
    logic [WB_DAT_W-1:0] mem [MEM_WORDS];

    // one clocked process handles both ports of the single-port RAM
    // the read takes the old word when a read and a write hit the
    // same address at the same edge, since both use nonblocking updates
    always_ff @(posedge wb_clk_i) begin
        if (ena_i) begin
            // the read side registers the addressed word on every enabled edge
            // and it holds its value while the RAM is not enabled
            rdata_o <= mem[addr_i];

            // each set bit of wen_i writes one byte lane
            // lane 0 is the least significant byte of the word
            for (int lane = 0; lane < WB_SEL_W; lane++) begin
                if (wen_i[lane]) begin
                    mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
                end
            end
        end
    end

    // a read cycle has wen_i all zero, so only the output register changes

    // the wrapper keeps ena_i high for the whole bus cycle, so a read
    // simply reloads the same word until the master drops its strobe

    // a write with a partial select leaves the other lanes of the word
    // untouched, which is how the slave merges byte and halfword stores

endmodule

//--- source/mem_wb.sv
// wishbone slave that maps classic bus cycles onto one soc_mem and generates the acknowledge
`timescale 1ns/1ps

module mem_wb #(
    // depth of the RAM behind this slave, in 32-bit words
    parameter int MEM_WORDS = wb_mem_pkg::MAIN_WORDS
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic [wb_mem_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic [wb_mem_pkg::WB_DAT_W-1:0] wb_dat_i,
    input  logic [wb_mem_pkg::WB_SEL_W-1:0] wb_sel_i,
    input  logic                            wb_we_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    output logic                            wb_ack_o,
    output logic [wb_mem_pkg::WB_DAT_W-1:0] wb_dat_o
);
    import wb_mem_pkg::*;

    // word index width for the RAM
    localparam int ADR_W = $clog2(MEM_WORDS);

    // a bus cycle is live while both cyc and stb are high
    logic                valid;
    // write cycle in progress
    logic                ram_we;
    // per-lane write enables handed to the RAM
    logic [WB_SEL_W-1:0] wen;
    // set for one cycle while a read waits for the RAM output register
    logic                rd_pend;

    assign valid  = wb_cyc_i & wb_stb_i;
    assign ram_we = wb_we_i & valid;

    // the select lines pick the byte lanes, but only during a write cycle
    assign wen = wb_sel_i & {WB_SEL_W{ram_we}};

    // acknowledge generation
    // a write is acked at the first edge that samples the strobe, since
    // the RAM takes the data at that same edge
    // a read first sets rd_pend, because the RAM output is only valid
    // after the edge that registered it, and acks one edge later
    // wb_ack_o is never raised again while it is already high, so a
    // strobe held into the ack cycle cannot start a second response
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            rd_pend  <= 1'b0;
            wb_ack_o <= 1'b0;
        end else begin
            if (wb_we_i) begin
                wb_ack_o <= valid & ~wb_ack_o;
            end else begin
                wb_ack_o <= rd_pend;
            end
            // rd_pend is a single-cycle flag
            // it cannot re-arm while it is set or while the ack is out
            rd_pend <= valid & ~wb_we_i & ~wb_ack_o & ~rd_pend;
        end
    end

    // the two low address bits select a byte and are dropped here
    // the base of the window is aligned to its size, so no subtraction is needed
    soc_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .wb_clk_i (wb_clk_i),
        .ena_i    (valid),
        .wen_i    (wen),
        .addr_i   (wb_adr_i[ADR_W+1:2]),
        .wdata_i  (wb_dat_i),
        .rdata_o  (wb_dat_o)
    );

endmodule

//--- source/wb_decoder.sv
// wishbone address decoder that steers the strobe to main or scratch RAM and errors unmapped cycles
`timescale 1ns/1ps

module wb_decoder (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic [wb_mem_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    output logic [wb_mem_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,
    output logic                            main_stb_o,
    output logic                            scratch_stb_o,
    input  logic                            main_ack_i,
    input  logic [wb_mem_pkg::WB_DAT_W-1:0] main_dat_i,
    input  logic                            scratch_ack_i,
    input  logic [wb_mem_pkg::WB_DAT_W-1:0] scratch_dat_i
);
    import wb_mem_pkg::*;

    // byte offset of the current address from the base of each window
    logic [WB_ADR_W-1:0] main_off;
    logic [WB_ADR_W-1:0] scratch_off;
    // address falls inside the window
    logic                main_hit;
    logic                scratch_hit;
    // master has a cycle on the bus
    logic                valid;
    // live cycle that no slave claims
    logic                miss;

    // window check
    // the subtraction wraps for addresses below the base, which turns
    // them into large offsets that fail the length compare, so a single
    // unsigned compare covers both ends of the window
    assign main_off    = wb_adr_i - MAIN_BASE;
    assign scratch_off = wb_adr_i - SCRATCH_BASE;
    assign main_hit    = main_off < MAIN_SPAN;
    assign scratch_hit = scratch_off < SCRATCH_SPAN;

    // only the slave that owns the address sees the strobe
    // cyc goes to both slaves unchanged from the top level
    assign main_stb_o    = wb_stb_i & main_hit;
    assign scratch_stb_o = wb_stb_i & scratch_hit;

    assign valid = wb_cyc_i & wb_stb_i;
    assign miss  = valid & ~main_hit & ~scratch_hit;

    // error response for unmapped addresses
    // err follows the same one-cycle timing as a write ack, and it is
    // held off while already high so that a strobe still present in
    // the err cycle does not produce a second pulse
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wb_err_o <= 1'b0;
        end else begin
            wb_err_o <= miss & ~wb_err_o;
        end
    end

    // response mux
    // the master holds the address until it sees ack or err, so the
    // current address still selects the right slave when its ack arrives
    // with no match both ack and data return zero
    always_comb begin
        wb_ack_o = 1'b0;
        wb_dat_o = '0;
        if (main_hit) begin
            wb_ack_o = main_ack_i;
            wb_dat_o = main_dat_i;
        end else if (scratch_hit) begin
            wb_ack_o = scratch_ack_i;
            wb_dat_o = scratch_dat_i;
        end
    end

    // the two windows never overlap, so the priority of main over
    // scratch in the mux above never decides anything in practice

    // the registered RAM output stays put between cycles, which is
    // why the data is returned without gating it by the ack

    // err is the only state in the decoder, all routing is combinational

endmodule

//--- source/wb_mem_top.sv
// top level of the wishbone memory subsystem, joining the decoder to the main and scratch RAM slaves
`timescale 1ns/1ps

module wb_mem_top (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    // master request
    input  logic [wb_mem_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic [wb_mem_pkg::WB_DAT_W-1:0] wb_dat_i,
    input  logic [wb_mem_pkg::WB_SEL_W-1:0] wb_sel_i,
    input  logic                            wb_we_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    // response to the master
    output logic [wb_mem_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o
);
    import wb_mem_pkg::*;

    // strobes from the decoder, one per slave
    logic                main_stb;
    logic                scratch_stb;
    // responses coming back from the slaves
    logic                main_ack;
    logic                scratch_ack;
    logic [WB_DAT_W-1:0] main_dat;
    logic [WB_DAT_W-1:0] scratch_dat;

    // the decoder owns err and the response mux
    wb_decoder u_decoder (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .wb_adr_i      (wb_adr_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .wb_err_o      (wb_err_o),
        .main_stb_o    (main_stb),
        .scratch_stb_o (scratch_stb),
        .main_ack_i    (main_ack),
        .main_dat_i    (main_dat),
        .scratch_ack_i (scratch_ack),
        .scratch_dat_i (scratch_dat)
    );

    // 1 KB main RAM
    // address, data, select, we and cyc fan out to both slaves
    mem_wb #(
        .MEM_WORDS (MAIN_WORDS)
    ) u_main_ram (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (main_stb),
        .wb_ack_o (main_ack),
        .wb_dat_o (main_dat)
    );

    // 256 B scratch RAM, same slave with a smaller array
    mem_wb #(
        .MEM_WORDS (SCRATCH_WORDS)
    ) u_scratch_ram (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (scratch_stb),
        .wb_ack_o (scratch_ack),
        .wb_dat_o (scratch_dat)
    );

endmodule

//--- bench/wb_mem_assertions.sv
// protocol checks on one wishbone RAM slave, bound into every mem_wb instance by the testbench
`timescale 1ns/1ps

module wb_mem_assertions (
    input logic wb_clk_i,
    input logic rst_i,
    input logic wb_cyc_i,
    input logic wb_ack_i
);

    // count of failed assertions in this slave
    int unsigned fail_count;

    initial begin
        fail_count = 0;
    end

    // an acknowledge is a single-cycle pulse
    // the slave suppresses a new ack while its own ack is still high,
    // even if the master keeps the strobe up through the ack cycle
    property ack_single_cycle;
        @(posedge wb_clk_i) disable iff (rst_i)
        wb_ack_i |=> !wb_ack_i;
    endproperty

    a_ack_single_cycle: assert property (ack_single_cycle)
        else begin
            fail_count++;
            $error("slave ack stayed high for two cycles in a row");
        end

    // ack only answers a cycle that the master has opened
    // cyc must have been high at the edge that raised the ack
    property ack_needs_cyc;
        @(posedge wb_clk_i) disable iff (rst_i)
        $rose(wb_ack_i) |-> $past(wb_cyc_i);
    endproperty

    a_ack_needs_cyc: assert property (ack_needs_cyc)
        else begin
            fail_count++;
            $error("slave ack rose without an open bus cycle");
        end

    // a synchronous reset clears the ack at the next edge
    // the check has no disable because it is about the reset itself
    property ack_low_after_reset;
        @(posedge wb_clk_i)
        rst_i |=> !wb_ack_i;
    endproperty

    a_ack_low_after_reset: assert property (ack_low_after_reset)
        else begin
            fail_count++;
            $error("slave ack was high right after reset");
        end

    // the read-pending flag is internal to the slave, so these checks
    // only look at what the decoder and master can observe

endmodule

//--- bench/tb_wb_mem.sv
// testbench for the wishbone memory subsystem, replays the bus-cycle trace and checks every response
`timescale 1ns/1ps

module tb_wb_mem;
    import wb_mem_pkg::*;

    // clock period in ns and reset length in cycles
    localparam int    CLK_PERIOD      = 10;
    localparam int    RESET_CYCLES    = 10;
    // watchdog budget for one trace entry in clock cycles
    localparam int    CYCLES_PER_LINE = 10;
    localparam string TRACE_FILE      = "bench/wb_mem_trace.txt";

    logic                wb_clk_i;
    logic                rst_i;
    logic [WB_ADR_W-1:0] wb_adr_i;
    logic [WB_DAT_W-1:0] wb_dat_i;
    logic [WB_SEL_W-1:0] wb_sel_i;
    logic                wb_we_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic [WB_DAT_W-1:0] wb_dat_o;
    logic                wb_ack_o;
    logic                wb_err_o;

    // trace columns, one entry per bus cycle
    logic [7:0]          op_q[$];
    logic [WB_ADR_W-1:0] adr_q[$];
    logic [WB_DAT_W-1:0] wdat_q[$];
    logic [WB_SEL_W-1:0] sel_q[$];
    logic [WB_DAT_W-1:0] rdat_q[$];
    logic [7:0]          resp_q[$];

    // the watchdog starts counting once the trace length is known
    logic   trace_loaded;
    integer seed;
    // trace entry currently on the bus and the window it addresses
    int     cur_line;
    string  cur_region;

    wb_mem_top DUT (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o)
    );

    // one protocol checker lands in each RAM slave
    bind mem_wb wb_mem_assertions u_ack_checker (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_ack_i (wb_ack_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
    end

    // names the window that an address belongs to
    function automatic string region_name(input logic [WB_ADR_W-1:0] adr);
        if (adr - MAIN_BASE < MAIN_WORDS * 4) begin
            return $sformatf("main RAM address 0x%h", adr);
        end else if (adr - SCRATCH_BASE < SCRATCH_WORDS * 4) begin
            return $sformatf("scratch RAM address 0x%h", adr);
        end
        return $sformatf("unmapped address 0x%h", adr);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        if (cur_line >= 0) begin
            $display("  during trace entry %0d, %s", cur_line, cur_region);
        end
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                        $time, name, actual, expected));
        end
    endtask

    // outside a bus cycle the master must never see a response
    task automatic expect_idle();
        check_value("wb_ack_o", {31'd0, wb_ack_o}, 32'd0);
        check_value("wb_err_o", {31'd0, wb_err_o}, 32'd0);
    endtask

    task automatic load_trace();
        int                  fd;
        int                  n;
        string               line;
        logic [7:0]          op_c;
        logic [7:0]          resp_c;
        logic [WB_ADR_W-1:0] adr_v;
        logic [WB_DAT_W-1:0] dat_v;
        logic [WB_DAT_W-1:0] exp_v;
        logic [WB_SEL_W-1:0] sel_v;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            stop_with_failure({"could not open the trace file ", TRACE_FILE});
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // lines that start with a hash are comments and blank lines are skipped
            if (n > 0 && line[0] != "#" && line[0] != "\n" && line[0] != "\r") begin
                n = $sscanf(line, "%c %h %h %h %h %c", op_c, adr_v, dat_v, sel_v, exp_v,
                            resp_c);
                if (n != 6 || (op_c != "W" && op_c != "R") ||
                    (resp_c != "A" && resp_c != "E")) begin
                    stop_with_failure({"the trace holds a line that cannot be read: ", line});
                end
                op_q.push_back(op_c);
                adr_q.push_back(adr_v);
                wdat_q.push_back(dat_v);
                sel_q.push_back(sel_v);
                rdat_q.push_back(exp_v);
                resp_q.push_back(resp_c);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            stop_with_failure("the trace file holds no bus cycles");
        end
    endtask

    // drives one classic cycle and checks the response and its timing
    task automatic run_bus_cycle(input int idx);
        logic is_write;
        logic exp_err;
        int   exp_lat;
        int   lat;
        is_write   = (op_q[idx] == "W");
        exp_err    = (resp_q[idx] == "E");
        // writes and errors answer one edge after the sampling edge
        // a read needs one more edge for the registered RAM output
        exp_lat    = (is_write || exp_err) ? 1 : 2;
        cur_line   = idx;
        cur_region = region_name(adr_q[idx]);
        @(negedge wb_clk_i);
        expect_idle();
        wb_adr_i = adr_q[idx];
        wb_dat_i = wdat_q[idx];
        wb_sel_i = sel_q[idx];
        wb_we_i  = is_write;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        // every falling edge here follows one rising edge of the cycle
        lat = 0;
        do begin
            @(negedge wb_clk_i);
            lat++;
        end while (!wb_ack_o && !wb_err_o);
        check_value("response latency", 32'(lat), 32'(exp_lat));
        check_value("wb_ack_o", {31'd0, wb_ack_o}, {31'd0, ~exp_err});
        check_value("wb_err_o", {31'd0, wb_err_o}, {31'd0, exp_err});
        if (!is_write && !exp_err) begin
            check_value("wb_dat_o", wb_dat_o, rdat_q[idx]);
        end
        // the master only notices the response at the next rising edge,
        // so the strobe is still high there and the pulse must end anyway
        @(negedge wb_clk_i);
        expect_idle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_sel_i = '0;
    endtask

    // random idle time of 0 to 3 cycles added after the idle cycle
    // that every bus cycle already starts with
    task automatic idle_gap();
        int extra;
        extra = $random(seed) & 3;
        repeat (extra) begin
            @(negedge wb_clk_i);
            expect_idle();
        end
    endtask

    initial begin
        rst_i        = 1'b1;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = '0;
        wb_we_i      = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        trace_loaded = 1'b0;
        seed         = 32'h947d_2f9f;
        cur_line     = -1;
        cur_region   = "";
        load_trace();
        trace_loaded = 1'b1;
        // responses must stay low for the whole reset
        repeat (RESET_CYCLES) begin
            @(negedge wb_clk_i);
            expect_idle();
        end
        rst_i = 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            run_bus_cycle(i);
            idle_gap();
        end
        if (DUT.u_main_ram.u_ack_checker.fail_count != 0 ||
            DUT.u_scratch_ram.u_ack_checker.fail_count != 0) begin
            stop_with_failure("a protocol assertion on a RAM slave failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    // a failed protocol assertion in either slave ends the run at once
    initial begin
        wait (DUT.u_main_ram.u_ack_checker.fail_count != 0 ||
              DUT.u_scratch_ram.u_ack_checker.fail_count != 0);
        stop_with_failure("a protocol assertion on a RAM slave failed");
    end

    // watchdog sized from the trace length plus the reset time
    initial begin
        wait (trace_loaded);
        #((op_q.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
        stop_with_failure("timeout, the bus stopped answering and no ack or err arrived");
    end

endmodule

//--- bench/wb_mem_trace.txt
# columns: op addr wdata sel exp_rdata resp, numbers in hex
# op is W (write) or R (read), resp is A (ack) or E (err), exp_rdata is checked on acked reads
W 00000000 a5a5a5a5 f 00000000 A
W 000003fc 5a5a5a5a f 00000000 A
W 00000200 01234567 f 00000000 A
R 00000000 00000000 f a5a5a5a5 A
R 000003fc 00000000 f 5a5a5a5a A
R 00000200 00000000 f 01234567 A
W 00001000 deadbeef f 00000000 A
W 000010fc cafef00d f 00000000 A
W 00001080 13572468 f 00000000 A
R 00001000 00000000 f deadbeef A
R 000010fc 00000000 f cafef00d A
R 00001080 00000000 f 13572468 A
# same word offsets in the other window stay apart
R 00000000 00000000 f a5a5a5a5 A
W 00000080 77777777 f 00000000 A
R 00001080 00000000 f 13572468 A
R 00000080 00000000 f 77777777 A
W 000000fc 99999999 f 00000000 A
R 000010fc 00000000 f cafef00d A
# byte and halfword writes merge into the stored word
W 00000200 000000ff 1 00000000 A
R 00000200 00000000 f 012345ff A
W 00000200 0000ab00 2 00000000 A
W 00000200 00cd0000 4 00000000 A
W 00000200 ef000000 8 00000000 A
R 00000200 00000000 f efcdabff A
W 00000200 00001234 3 00000000 A
R 00000200 00000000 f efcd1234 A
W 00000200 56780000 c 00000000 A
R 00000200 00000000 f 56781234 A
W 00001000 00000011 1 00000000 A
W 00001000 22220000 c 00000000 A
R 00001000 00000000 f 2222be11 A
W 00001000 0000ff00 0 00000000 A
R 00001000 00000000 f 2222be11 A
W 000003fc 00aa00bb 5 00000000 A
R 000003fc 00000000 f 5aaa5abb A
# unmapped addresses end with err and leave the RAMs alone
W 00000400 ffffffff f 00000000 E
R 00000ffc 00000000 f 00000000 E
W 00001100 ffffffff f 00000000 E
R 80000000 00000000 f 00000000 E
W 00000ffc ffffffff f 00000000 E
R 00000000 00000000 f a5a5a5a5 A
R 000003fc 00000000 f 5aaa5abb A
R 000010fc 00000000 f cafef00d A
R 00001000 00000000 f 2222be11 A

//--- list.f
source/wb_mem_pkg.sv
source/soc_mem.sv
source/mem_wb.sv
source/wb_decoder.sv
source/wb_mem_top.sv
bench/wb_mem_assertions.sv
bench/tb_wb_mem.sv

//--- Makefile
# Verilator build and run of the wishbone memory testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_mem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# build, run, and decide the result from the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
